/* Makefile */
VERILATOR ?= verilator
FILELIST ?= sim.f
TB_TOP ?= execute_top_tb
RTL_TOP ?= execute_top
BUILD_DIR ?= obj_dir
LOG ?= sim.log
SIM_FLAGS ?= --binary --timing --assert -j 0
FAIL_MSG ?= Test failures found
PASS_MSG ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/execute_stim.txt */
// lane0 then lane1, each: valid op rd rs1 rs2 imm pc
// expected: valid0 rd0 data0 valid1 rd1 data1 redirect redirect_pc stall
1 b 01 00 00 12345000 100  1 b 02 00 00 7 104  1 01 12345000 1 02 7 0 0 0
1 1 03 01 02 0 108  1 b 04 00 00 fffffff0 10c  1 03 12345007 1 04 fffffff0 0 0 0
1 2 05 02 04 0 110  1 3 06 01 03 0 114  1 05 17 1 06 12345000 0 0 0
1 4 07 01 02 0 118  1 5 08 03 04 0 11c  1 07 12345007 1 08 edcbaff7 0 0 0
1 6 09 01 02 0 120  1 7 0a 04 02 0 124  1 09 1a280000 1 0a 01ffffff 0 0 0
1 8 0b 04 02 0 128  1 9 0c 04 02 0 12c  1 0b ffffffff 1 0c 1 0 0 0
1 a 0d 04 02 0 130  1 a 0e 02 04 0 134  1 0d 0 1 0e 1 0 0 0
1 9 0f 02 04 0 138  1 8 10 01 02 0 13c  1 0f 0 1 10 002468a0 0 0 0
1 b 11 00 00 21 140  1 b 11 00 00 55 144  1 11 21 1 11 55 0 0 0
1 1 12 11 00 0 148  1 b 00 00 00 dead0000 14c  1 12 55 1 00 dead0000 0 0 0
1 1 13 00 11 0 150  1 6 14 02 11 0 154  1 13 55 1 14 00e00000 0 0 0
1 1 15 11 12 0 158  1 1 16 13 14 0 15c  1 15 aa 1 16 00e00055 0 0 0
1 c 00 02 02 40 160  1 1 17 01 02 0 164  0 00 0 0 00 0 1 1a0 0
1 d 00 02 02 40 168  1 1 17 02 02 0 16c  0 00 0 1 17 e 0 0 0
1 1 18 02 04 0 170  1 e 00 04 02 fffffff0 174  1 18 fffffff7 0 00 0 1 164 0
1 e 00 02 04 20 178  1 4 19 02 11 0 17c  0 00 0 1 19 57 0 0 0
1 0 00 00 00 0 180  1 f 00 02 04 100 184  0 00 0 0 00 0 1 284 0
1 f 00 04 02 10 188  1 b 1a 00 00 80000000 18c  0 00 0 1 1a 80000000 0 0 0
1 10 1b 00 00 200 190  1 1 1c 01 01 0 194  1 1b 194 0 00 0 1 390 0
1 b 1e 00 00 ffffffff 198  1 10 1d 00 00 fffffe00 19c  1 1e ffffffff 1 1d 1a0 1 ffffff9c 0
1 d 00 01 02 60 1a0  1 b 1f 00 00 1 1a4  0 00 0 0 00 0 1 200 0
1 b 1c 00 00 abc 1a8  1 c 00 01 02 8 1ac  1 1c abc 0 00 0 0 0 0
1 11 1f 04 02 0 1b0  1 1 09 02 02 0 1b4  1 1f fffffffe 1 09 e 0 0 1
1 1 0a 02 1f 0 1b8  1 12 0b 04 02 0 1bc  1 0a 5 1 0b 24924922 0 0 1
1 14 0c 04 02 0 1c0  0 0 00 00 00 0 1c4  1 0c 2 0 00 0 0 0 1
1 11 0d 02 00 0 1c8  1 2 0e 04 02 0 1cc  1 0d ffffffff 1 0e ffffffe9 0 0 1
1 1 0f 1a 00 0 1d0  1 13 10 04 00 0 1d4  1 0f 80000000 1 10 fffffff0 0 0 1
1 11 11 1a 1e 0 1d8  0 0 00 00 00 0 1dc  1 11 80000000 0 00 0 0 0 1
1 1 12 11 02 0 1e0  1 13 13 1a 1e 0 1e4  1 12 80000007 1 13 0 0 0 1
1 12 14 12 00 0 1e8  0 0 00 00 00 0 1ec  1 14 ffffffff 0 00 0 0 0 1
1 1 15 14 02 0 1f0  1 14 16 01 00 0 1f4  1 15 6 1 16 12345000 0 0 1

/* dv/execute_top_tb.sv */
`timescale 1ns/1ps

module execute_top_tb;
  import exec_pkg::*;

  localparam int xlen = 32;
  localparam int clock_period = 40;
  localparam int reset_cycles = 8;
  localparam int num_pairs = 31;
  // stimulus line layout in words.
  localparam int fields = 23;
  localparam int lane_fields = 7;
  localparam int exp_base = 14;
  localparam int timeout_cycles = num_pairs * (xlen + 4) + 100;

  logic clock;
  logic reset;
  logic issue0_valid;
  op_type issue0_op;
  logic [reg_addr_bits-1:0] issue0_rd;
  logic [reg_addr_bits-1:0] issue0_rs1;
  logic [reg_addr_bits-1:0] issue0_rs2;
  logic [xlen-1:0] issue0_imm;
  logic [xlen-1:0] issue0_pc;
  logic issue1_valid;
  op_type issue1_op;
  logic [reg_addr_bits-1:0] issue1_rd;
  logic [reg_addr_bits-1:0] issue1_rs1;
  logic [reg_addr_bits-1:0] issue1_rs2;
  logic [xlen-1:0] issue1_imm;
  logic [xlen-1:0] issue1_pc;
  logic stall;
  logic result0_valid;
  logic [reg_addr_bits-1:0] result0_rd;
  logic [xlen-1:0] result0_data;
  logic result1_valid;
  logic [reg_addr_bits-1:0] result1_rd;
  logic [xlen-1:0] result1_data;
  logic redirect;
  logic [xlen-1:0] redirect_pc;
  logic [xlen-1:0] stim_mem [0:num_pairs*fields-1];
  int cycle_count = 0;

  execute_top #(.xlen(xlen)) dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1);
  endtask

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      abort_run($sformatf("timeout, the run did not finish within %0d cycles", timeout_cycles));
    end
  end

  function automatic string test_name(input int idx, input string what);
    return $sformatf("pair %0d %s", idx, what);
  endfunction

  function automatic logic stim_flag(input int pos);
    return stim_mem[pos][0];
  endfunction

  function automatic logic [reg_addr_bits-1:0] stim_rd(input int pos);
    return stim_mem[pos][reg_addr_bits-1:0];
  endfunction

  task automatic check_data(input string name, input logic [xlen-1:0] expected,
                            input logic [xlen-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("error %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_rd(input string name, input logic [reg_addr_bits-1:0] expected,
                          input logic [reg_addr_bits-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("error %s expected x%0d actual x%0d", name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("error %s expected %b actual %b", name, expected, actual));
    end
  endtask

  task automatic drive_pair(input int idx);
    int b;
    b = idx * fields;
    issue0_valid <= stim_flag(b);
    issue0_op <= op_type'(stim_mem[b + 1][4:0]);
    issue0_rd <= stim_rd(b + 2);
    issue0_rs1 <= stim_rd(b + 3);
    issue0_rs2 <= stim_rd(b + 4);
    issue0_imm <= stim_mem[b + 5];
    issue0_pc <= stim_mem[b + 6];
    b = b + lane_fields;
    issue1_valid <= stim_flag(b);
    issue1_op <= op_type'(stim_mem[b + 1][4:0]);
    issue1_rd <= stim_rd(b + 2);
    issue1_rs1 <= stim_rd(b + 3);
    issue1_rs2 <= stim_rd(b + 4);
    issue1_imm <= stim_mem[b + 5];
    issue1_pc <= stim_mem[b + 6];
  endtask

  // rd and data only matter when the result is valid.
  task automatic check_results(input int idx);
    int b;
    b = idx * fields + exp_base;
    check_flag(test_name(idx, "result0_valid"), stim_flag(b), result0_valid);
    if (stim_flag(b)) begin
      check_rd(test_name(idx, "result0_rd"), stim_rd(b + 1), result0_rd);
      check_data(test_name(idx, "result0_data"), stim_mem[b + 2], result0_data);
    end
    check_flag(test_name(idx, "result1_valid"), stim_flag(b + 3), result1_valid);
    if (stim_flag(b + 3)) begin
      check_rd(test_name(idx, "result1_rd"), stim_rd(b + 4), result1_rd);
      check_data(test_name(idx, "result1_data"), stim_mem[b + 5], result1_data);
    end
    check_flag(test_name(idx, "redirect"), stim_flag(b + 6), redirect);
    if (stim_flag(b + 6)) begin
      check_data(test_name(idx, "redirect_pc"), stim_mem[b + 7], redirect_pc);
    end
  endtask

  task automatic wait_for_accept(input int idx);
    int b;
    b = idx * fields + exp_base;
    check_flag(test_name(idx, "stall"), stim_flag(b + 8), stall);
    while (stall) begin
      @(negedge clock);
      // the stage loads bubbles while the pair is held.
      check_flag(test_name(idx, "bubble result0_valid"), 1'b0, result0_valid);
      check_flag(test_name(idx, "bubble result1_valid"), 1'b0, result1_valid);
      check_flag(test_name(idx, "bubble redirect"), 1'b0, redirect);
    end
  endtask

  initial begin
    reset = 1'b0;
    issue0_valid = 1'b0;
    issue0_op = op_nop;
    issue0_rd = '0;
    issue0_rs1 = '0;
    issue0_rs2 = '0;
    issue0_imm = '0;
    issue0_pc = '0;
    issue1_valid = 1'b0;
    issue1_op = op_nop;
    issue1_rd = '0;
    issue1_rs1 = '0;
    issue1_rs2 = '0;
    issue1_imm = '0;
    issue1_pc = '0;
    $readmemh("dv/execute_stim.txt", stim_mem);
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b1;
    @(negedge clock);
    check_flag("reset result0_valid", 1'b0, result0_valid);
    check_flag("reset result1_valid", 1'b0, result1_valid);
    check_flag("reset redirect", 1'b0, redirect);
    check_flag("reset stall", 1'b0, stall);
    for (int i = 0; i < num_pairs; i++) begin
      @(posedge clock);
      drive_pair(i);
      @(negedge clock);
      if (i > 0) begin
        check_results(i - 1);
      end
      wait_for_accept(i);
    end
    @(posedge clock);
    issue0_valid <= 1'b0;
    issue1_valid <= 1'b0;
    @(negedge clock);
    check_results(num_pairs - 1);
    repeat (2) @(posedge clock);
    $display("All tests passed!");
    $finish;
  end

endmodule

/* hdl/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit #(
  parameter int xlen = 32
) (
  input logic enable,
  input exec_pkg::op_type op,
  input logic [xlen-1:0] rdata1,
  input logic [xlen-1:0] rdata2,
  input logic [xlen-1:0] pc,
  input logic [xlen-1:0] imm,
  output logic taken,
  output logic [xlen-1:0] target
);
  import exec_pkg::*;

  logic cond;

  always_comb begin
    case (op)
      op_beq: cond = (rdata1 == rdata2);
      op_bne: cond = (rdata1 != rdata2);
      op_blt: cond = ($signed(rdata1) < $signed(rdata2));
      op_bge: cond = ($signed(rdata1) >= $signed(rdata2));
      op_jal: cond = 1'b1;
      default: cond = 1'b0;
    endcase
    taken = enable & cond;
    target = pc + imm;
  end

endmodule

/* hdl/exec_pkg.sv */
package exec_pkg;

  localparam int reg_addr_bits = 5;

  // operations understood by the execute block.
  typedef enum logic [4:0] {
    op_nop,
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_srl,
    op_sra,
    op_slt,
    op_sltu,
    op_lui,
    op_beq,
    op_bne,
    op_blt,
    op_bge,
    op_jal,
    op_div,
    op_divu,
    op_rem,
    op_remu
  } op_type;

  typedef enum logic [1:0] {
    div_idle,
    div_run,
    div_done
  } div_state_type;

endpackage

/* hdl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage #(
  parameter int xlen = 32
) (
  input logic clock,
  input logic reset,
  input logic issue0_valid,
  input logic issue1_valid,
  input exec_pkg::op_type issue0_op,
  input exec_pkg::op_type issue1_op,
  input logic [exec_pkg::reg_addr_bits-1:0] issue0_rd,
  input logic [exec_pkg::reg_addr_bits-1:0] issue1_rd,
  input logic [xlen-1:0] issue0_imm,
  input logic [xlen-1:0] issue1_imm,
  input logic [xlen-1:0] issue0_pc,
  input logic [xlen-1:0] issue1_pc,
  input logic [xlen-1:0] opnd0,
  input logic [xlen-1:0] opnd1,
  input logic [xlen-1:0] opnd2,
  input logic [xlen-1:0] opnd3,
  input logic [xlen-1:0] alu0_result,
  input logic [xlen-1:0] alu1_result,
  input logic br_taken,
  input logic [xlen-1:0] br_target,
  input logic div_ready,
  input logic [xlen-1:0] div_result,
  output exec_pkg::op_type alu0_op,
  output exec_pkg::op_type alu1_op,
  output logic br_enable,
  output exec_pkg::op_type br_op,
  output logic [xlen-1:0] br_rdata1,
  output logic [xlen-1:0] br_rdata2,
  output logic [xlen-1:0] br_pc,
  output logic [xlen-1:0] br_imm,
  output logic div_start,
  output exec_pkg::op_type div_op,
  output logic [xlen-1:0] div_dividend,
  output logic [xlen-1:0] div_divisor,
  output logic stall,
  output logic result0_valid,
  output logic [exec_pkg::reg_addr_bits-1:0] result0_rd,
  output logic [xlen-1:0] result0_data,
  output logic result1_valid,
  output logic [exec_pkg::reg_addr_bits-1:0] result1_rd,
  output logic [xlen-1:0] result1_data,
  output logic redirect,
  output logic [xlen-1:0] redirect_pc
);
  import exec_pkg::*;

  logic ctrl0;
  logic ctrl1;
  logic div0;
  logic div1;
  logic div_req;
  logic div_pending;
  logic taken0;
  logic taken1;
  logic keep1;
  logic [xlen-1:0] wdata0;
  logic [xlen-1:0] wdata1;

  function automatic logic is_ctrl(input op_type op);
    return op inside {op_beq, op_bne, op_blt, op_bge, op_jal};
  endfunction

  function automatic logic is_div(input op_type op);
    return op inside {op_div, op_divu, op_rem, op_remu};
  endfunction

  // conditional branches and nop leave the register file alone.
  function automatic logic writes_rd(input op_type op);
    return !(op inside {op_nop, op_beq, op_bne, op_blt, op_bge});
  endfunction

  always_comb begin
    alu0_op = issue0_valid ? issue0_op : op_nop;
    alu1_op = issue1_valid ? issue1_op : op_nop;

    ctrl0 = issue0_valid & is_ctrl(issue0_op);
    ctrl1 = issue1_valid & is_ctrl(issue1_op);
    br_enable = ctrl0 | ctrl1;
    br_op = ctrl0 ? issue0_op : issue1_op;
    br_rdata1 = ctrl0 ? opnd0 : opnd2;
    br_rdata2 = ctrl0 ? opnd1 : opnd3;
    br_pc = ctrl0 ? issue0_pc : issue1_pc;
    br_imm = ctrl0 ? issue0_imm : issue1_imm;

    taken0 = ctrl0 & br_taken;
    taken1 = ctrl1 & ~ctrl0 & br_taken;
    // younger lane dies behind a taken transfer.
    keep1 = issue1_valid & ~taken0;

    div0 = issue0_valid & is_div(issue0_op);
    div1 = keep1 & is_div(issue1_op);
    div_req = div0 | div1;
    div_start = div_req & ~div_pending;
    div_op = div0 ? issue0_op : issue1_op;
    div_dividend = div0 ? opnd0 : opnd2;
    div_divisor = div0 ? opnd1 : opnd3;
    stall = div_req & ~div_ready;

    wdata0 = div0 ? div_result : alu0_result;
    wdata1 = div1 ? div_result : alu1_result;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      div_pending <= 1'b0;
    end else if (div_start) begin
      div_pending <= 1'b1;
    end else if (div_ready) begin
      div_pending <= 1'b0;
    end
  end

  // bubble while stalled.
  always_ff @(posedge clock) begin
    if (!reset) begin
      result0_valid <= 1'b0;
      result1_valid <= 1'b0;
      redirect <= 1'b0;
    end else begin
      result0_valid <= ~stall & issue0_valid & writes_rd(issue0_op);
      result1_valid <= ~stall & keep1 & writes_rd(issue1_op);
      redirect <= ~stall & (taken0 | taken1);
    end
  end

  always_ff @(posedge clock) begin
    result0_rd <= issue0_rd;
    result0_data <= wdata0;
    result1_rd <= issue1_rd;
    result1_data <= wdata1;
    redirect_pc <= br_target;
  end

  assert property (@(posedge clock) disable iff (!reset) !(ctrl0 && ctrl1));
  assert property (@(posedge clock) disable iff (!reset)
    !(div0 && issue1_valid && is_div(issue1_op)));

endmodule

/* hdl/execute_top.sv */
`timescale 1ns/1ps

module execute_top #(
  parameter int xlen = 32
) (
  input logic clock,
  input logic reset,
  input logic issue0_valid,
  input exec_pkg::op_type issue0_op,
  input logic [exec_pkg::reg_addr_bits-1:0] issue0_rd,
  input logic [exec_pkg::reg_addr_bits-1:0] issue0_rs1,
  input logic [exec_pkg::reg_addr_bits-1:0] issue0_rs2,
  input logic [xlen-1:0] issue0_imm,
  input logic [xlen-1:0] issue0_pc,
  input logic issue1_valid,
  input exec_pkg::op_type issue1_op,
  input logic [exec_pkg::reg_addr_bits-1:0] issue1_rd,
  input logic [exec_pkg::reg_addr_bits-1:0] issue1_rs1,
  input logic [exec_pkg::reg_addr_bits-1:0] issue1_rs2,
  input logic [xlen-1:0] issue1_imm,
  input logic [xlen-1:0] issue1_pc,
  output logic stall,
  output logic result0_valid,
  output logic [exec_pkg::reg_addr_bits-1:0] result0_rd,
  output logic [xlen-1:0] result0_data,
  output logic result1_valid,
  output logic [exec_pkg::reg_addr_bits-1:0] result1_rd,
  output logic [xlen-1:0] result1_data,
  output logic redirect,
  output logic [xlen-1:0] redirect_pc
);
  import exec_pkg::*;

  op_type alu0_op;
  op_type alu1_op;
  op_type br_op;
  op_type div_op;
  logic [xlen-1:0] alu0_result;
  logic [xlen-1:0] alu1_result;
  logic br_enable;
  logic br_taken;
  logic [xlen-1:0] br_rdata1;
  logic [xlen-1:0] br_rdata2;
  logic [xlen-1:0] br_pc;
  logic [xlen-1:0] br_imm;
  logic [xlen-1:0] br_target;
  logic div_start;
  logic div_ready;
  logic [xlen-1:0] div_dividend;
  logic [xlen-1:0] div_divisor;
  logic [xlen-1:0] div_result;
  logic [xlen-1:0] rf_rdata0;
  logic [xlen-1:0] rf_rdata1;
  logic [xlen-1:0] rf_rdata2;
  logic [xlen-1:0] rf_rdata3;
  logic [xlen-1:0] opnd0;
  logic [xlen-1:0] opnd1;
  logic [xlen-1:0] opnd2;
  logic [xlen-1:0] opnd3;

  execute_stage #(.xlen(xlen)) stage0 (.*);

  int_alu #(.xlen(xlen)) alu0 (
    .rdata1(opnd0),
    .rdata2(opnd1),
    .imm(issue0_imm),
    .pc(issue0_pc),
    .op(alu0_op),
    .result(alu0_result)
  );

  int_alu #(.xlen(xlen)) alu1 (
    .rdata1(opnd2),
    .rdata2(opnd3),
    .imm(issue1_imm),
    .pc(issue1_pc),
    .op(alu1_op),
    .result(alu1_result)
  );

  branch_unit #(.xlen(xlen)) branch0 (
    .enable(br_enable),
    .op(br_op),
    .rdata1(br_rdata1),
    .rdata2(br_rdata2),
    .pc(br_pc),
    .imm(br_imm),
    .taken(br_taken),
    .target(br_target)
  );

  serial_divider #(.xlen(xlen)) divider0 (
    .clock(clock),
    .reset(reset),
    .start(div_start),
    .op(div_op),
    .dividend(div_dividend),
    .divisor(div_divisor),
    .ready(div_ready),
    .result(div_result)
  );

  register_file #(.xlen(xlen)) regfile0 (
    .clock(clock),
    .reset(reset),
    .wen0(result0_valid),
    .wen1(result1_valid),
    .waddr0(result0_rd),
    .waddr1(result1_rd),
    .raddr0(issue0_rs1),
    .raddr1(issue0_rs2),
    .raddr2(issue1_rs1),
    .raddr3(issue1_rs2),
    .wdata0(result0_data),
    .wdata1(result1_data),
    .rdata0(rf_rdata0),
    .rdata1(rf_rdata1),
    .rdata2(rf_rdata2),
    .rdata3(rf_rdata3)
  );

  forwarding_unit #(.xlen(xlen)) forward0 (
    .raddr0(issue0_rs1),
    .raddr1(issue0_rs2),
    .raddr2(issue1_rs1),
    .raddr3(issue1_rs2),
    .fwd_rd0(result0_rd),
    .fwd_rd1(result1_rd),
    .fwd_valid0(result0_valid),
    .fwd_valid1(result1_valid),
    .reg_data0(rf_rdata0),
    .reg_data1(rf_rdata1),
    .reg_data2(rf_rdata2),
    .reg_data3(rf_rdata3),
    .fwd_data0(result0_data),
    .fwd_data1(result1_data),
    .data0(opnd0),
    .data1(opnd1),
    .data2(opnd2),
    .data3(opnd3)
  );

endmodule

/* hdl/forwarding_unit.sv */
`timescale 1ns/1ps

module forwarding_unit #(
  parameter int xlen = 32
) (
  input logic [exec_pkg::reg_addr_bits-1:0] raddr0,
  input logic [exec_pkg::reg_addr_bits-1:0] raddr1,
  input logic [exec_pkg::reg_addr_bits-1:0] raddr2,
  input logic [exec_pkg::reg_addr_bits-1:0] raddr3,
  input logic [exec_pkg::reg_addr_bits-1:0] fwd_rd0,
  input logic [exec_pkg::reg_addr_bits-1:0] fwd_rd1,
  input logic fwd_valid0,
  input logic fwd_valid1,
  input logic [xlen-1:0] reg_data0,
  input logic [xlen-1:0] reg_data1,
  input logic [xlen-1:0] reg_data2,
  input logic [xlen-1:0] reg_data3,
  input logic [xlen-1:0] fwd_data0,
  input logic [xlen-1:0] fwd_data1,
  output logic [xlen-1:0] data0,
  output logic [xlen-1:0] data1,
  output logic [xlen-1:0] data2,
  output logic [xlen-1:0] data3
);
  import exec_pkg::*;

  // the younger lane 1 result wins over lane 0.
  function automatic logic [xlen-1:0] bypass(input logic [reg_addr_bits-1:0] addr,
                                             input logic [xlen-1:0] reg_data);
    logic [xlen-1:0] data;
    data = reg_data;
    if (addr != '0) begin
      if (fwd_valid1 && fwd_rd1 == addr) begin
        data = fwd_data1;
      end else if (fwd_valid0 && fwd_rd0 == addr) begin
        data = fwd_data0;
      end
    end
    return data;
  endfunction

  always_comb begin
    data0 = bypass(raddr0, reg_data0);
    data1 = bypass(raddr1, reg_data1);
    data2 = bypass(raddr2, reg_data2);
    data3 = bypass(raddr3, reg_data3);
  end

endmodule

/* hdl/int_alu.sv */
`timescale 1ns/1ps

module int_alu #(
  parameter int xlen = 32
) (
  input logic [xlen-1:0] rdata1,
  input logic [xlen-1:0] rdata2,
  input logic [xlen-1:0] imm,
  input logic [xlen-1:0] pc,
  input exec_pkg::op_type op,
  output logic [xlen-1:0] result
);
  import exec_pkg::*;

  localparam int shamt_bits = $clog2(xlen);

  logic [shamt_bits-1:0] shamt;

  always_comb begin
    shamt = rdata2[shamt_bits-1:0];
    case (op)
      op_add: result = rdata1 + rdata2;
      op_sub: result = rdata1 - rdata2;
      op_and: result = rdata1 & rdata2;
      op_or: result = rdata1 | rdata2;
      op_xor: result = rdata1 ^ rdata2;
      op_sll: result = rdata1 << shamt;
      op_srl: result = rdata1 >> shamt;
      op_sra: result = $signed(rdata1) >>> shamt;
      op_slt: result = {{(xlen-1){1'b0}}, $signed(rdata1) < $signed(rdata2)};
      op_sltu: result = {{(xlen-1){1'b0}}, rdata1 < rdata2};
      op_lui: result = imm;
      // link value.
      op_jal: result = pc + xlen'(4);
      // branches and divides produce nothing here.
      default: result = '0;
    endcase
  end

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ps

module register_file #(
  parameter int xlen = 32
) (
  input logic clock,
  input logic reset,
  input logic wen0,
  input logic wen1,
  input logic [exec_pkg::reg_addr_bits-1:0] waddr0,
  input logic [exec_pkg::reg_addr_bits-1:0] waddr1,
  input logic [exec_pkg::reg_addr_bits-1:0] raddr0,
  input logic [exec_pkg::reg_addr_bits-1:0] raddr1,
  input logic [exec_pkg::reg_addr_bits-1:0] raddr2,
  input logic [exec_pkg::reg_addr_bits-1:0] raddr3,
  input logic [xlen-1:0] wdata0,
  input logic [xlen-1:0] wdata1,
  output logic [xlen-1:0] rdata0,
  output logic [xlen-1:0] rdata1,
  output logic [xlen-1:0] rdata2,
  output logic [xlen-1:0] rdata3
);
  import exec_pkg::*;

  localparam int depth = 1 << reg_addr_bits;

  logic [xlen-1:0] regs [0:depth-1];

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < depth; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wen0 && waddr0 != '0) begin
        regs[waddr0] <= wdata0;
      end
      // lane 1 is written last and wins a shared rd.
      if (wen1 && waddr1 != '0) begin
        regs[waddr1] <= wdata1;
      end
    end
  end

  assign rdata0 = regs[raddr0];
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];
  assign rdata3 = regs[raddr3];

endmodule

/* hdl/serial_divider.sv */
`timescale 1ns/1ps

module serial_divider #(
  parameter int xlen = 32
) (
  input logic clock,
  input logic reset,
  input logic start,
  input exec_pkg::op_type op,
  input logic [xlen-1:0] dividend,
  input logic [xlen-1:0] divisor,
  output logic ready,
  output logic [xlen-1:0] result
);
  import exec_pkg::*;

  localparam int cnt_bits = $clog2(xlen);

  div_state_type state;
  logic [cnt_bits-1:0] count;
  logic [xlen-1:0] quo;
  logic [xlen-1:0] rem;
  logic [xlen-1:0] dvs;
  logic neg_quo;
  logic neg_rem;
  logic want_rem;
  logic is_signed;
  logic a_neg;
  logic b_neg;
  logic [xlen:0] trial;

  always_comb begin
    is_signed = (op == op_div) || (op == op_rem);
    a_neg = is_signed & dividend[xlen-1];
    b_neg = is_signed & divisor[xlen-1];
    // msb set means the shifted remainder is below the divisor.
    trial = {rem, quo[xlen-1]} - {1'b0, dvs};
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= div_idle;
      count <= '0;
    end else begin
      case (state)
        div_idle: begin
          if (start) begin
            state <= div_run;
            count <= '0;
          end
        end
        div_run: begin
          count <= count + cnt_bits'(1);
          if (count == cnt_bits'(xlen - 1)) begin
            state <= div_done;
          end
        end
        div_done: state <= div_idle;
        default: state <= div_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (start && state == div_idle) begin
      quo <= a_neg ? -dividend : dividend;
      rem <= '0;
      dvs <= b_neg ? -divisor : divisor;
      // zero divisor keeps the all-ones quotient.
      neg_quo <= (a_neg ^ b_neg) & (divisor != '0);
      neg_rem <= a_neg;
      want_rem <= (op == op_rem) || (op == op_remu);
    end else if (state == div_run) begin
      if (trial[xlen]) begin
        rem <= {rem[xlen-2:0], quo[xlen-1]};
        quo <= {quo[xlen-2:0], 1'b0};
      end else begin
        rem <= trial[xlen-1:0];
        quo <= {quo[xlen-2:0], 1'b1};
      end
    end
  end

  always_comb begin
    ready = (state == div_done);
    if (want_rem) begin
      result = neg_rem ? -rem : rem;
    end else begin
      result = neg_quo ? -quo : quo;
    end
  end

  // a new division only starts from idle.
  assert property (@(posedge clock) disable iff (!reset) $rose(start) |-> state == div_idle);

endmodule

/* sim.f */
hdl/exec_pkg.sv
hdl/int_alu.sv
hdl/branch_unit.sv
hdl/serial_divider.sv
hdl/register_file.sv
hdl/forwarding_unit.sv
hdl/execute_stage.sv
hdl/execute_top.sv
dv/execute_top_tb.sv
